//--- rtl/tcdm_pkg.sv
`default_nettype none

package tcdm_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_MASTERS  = 4;  // requestors
  localparam int unsigned NUM_BANKS    = 4;  // single-port banks
  localparam int unsigned DATA_W       = 32; // word width
  localparam int unsigned BANK_SEL_W   = 2;  // low address bits pick the bank
  localparam int unsigned ROW_W        = 6;  // high address bits pick the row
  localparam int unsigned ADDR_W       = BANK_SEL_W + ROW_W; // word address, 8 bits
  localparam int unsigned MASTER_IDX_W = 2;
  localparam int unsigned BANK_DEPTH   = 2 ** ROW_W;         // 64 words per bank

  // wen + row + wdata, wen on top
  localparam int unsigned PAYLOAD_W    = 1 + ROW_W + DATA_W;

  //////////////////////////////////////////////////////////////////////
  // config register map
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CFG_ADDR_W = 1;

  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_WRESP = 1'b0; // write-response mask
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_PRIO  = 1'b1; // ext prio enable + fields

  // prio fields sit in 7..0, enable right above them
  localparam int unsigned EXT_PRIO_EN_BIT = NUM_BANKS * MASTER_IDX_W;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [ADDR_W-1:0]       word_addr_t;   // {row, bank}
  typedef logic [BANK_SEL_W-1:0]   bank_sel_t;
  typedef logic [ROW_W-1:0]        row_addr_t;
  typedef logic [MASTER_IDX_W-1:0] master_idx_t;
  typedef logic [PAYLOAD_W-1:0]    req_payload_t; // {wen, row, wdata}

endpackage

`default_nettype wire

//--- rtl/rr_arbiter.sv
`default_nettype none

module rr_arbiter (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // priority start override
  input  logic                                               ext_prio_en_i,
  input  tcdm_pkg::master_idx_t                              prio_i,
  // master side
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                   req_i,
  input  tcdm_pkg::req_payload_t [tcdm_pkg::NUM_MASTERS-1:0] payload_i,
  output logic [tcdm_pkg::NUM_MASTERS-1:0]                   gnt_o,
  // bank side
  output logic                                               req_o,
  input  logic                                               gnt_i,     // low while stalled
  output tcdm_pkg::req_payload_t                             payload_o
);

  tcdm_pkg::master_idx_t rr_ptr_q;   // next master to be favoured
  tcdm_pkg::master_idx_t start_idx;  // where the search begins this cycle
  tcdm_pkg::master_idx_t win_idx;
  logic                  win_vld;
  logic                  xfer;

  //////////////////////////////////////////////////////////////////////
  // rotating first-one search
  //////////////////////////////////////////////////////////////////////

  assign start_idx = ext_prio_en_i ? prio_i : rr_ptr_q; // external prio wins over pointer

  always_comb begin : win_search
    tcdm_pkg::master_idx_t cand;
    win_idx = start_idx;
    win_vld = 1'b0;
    for (int unsigned i = 0; i < tcdm_pkg::NUM_MASTERS; i++) begin
      cand = start_idx + tcdm_pkg::master_idx_t'(i); // wraps mod 4
      if (!win_vld && req_i[cand]) begin
        win_vld = 1'b1;
        win_idx = cand;
      end
    end
  end

  // bank sees a request whenever anybody asks
  assign req_o     = win_vld;
  assign payload_o = payload_i[win_idx]; // don't care when nobody asks
  assign xfer      = win_vld & gnt_i;

  // one-hot grant back, nothing while the bank stalls
  always_comb begin
    gnt_o = '0;
    if (xfer) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointer update
  //////////////////////////////////////////////////////////////////////

  // moves only on an actual transfer, also under external prio
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
    end else if (xfer) begin
      rr_ptr_q <= win_idx + tcdm_pkg::master_idx_t'(1); // winner + 1
    end
  end

endmodule

`default_nettype wire

//--- rtl/addr_dec_resp_mux.sv
`default_nettype none

module addr_dec_resp_mux (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic                                       wresp_en_i, // vld_o after writes too
  // master side
  input  logic                                       req_i,
  input  tcdm_pkg::word_addr_t                       addr_i,
  input  logic                                       wen_i,      // 1 store, 0 load
  input  tcdm_pkg::data_t                            wdata_i,
  output logic                                       gnt_o,
  output logic                                       vld_o,
  output tcdm_pkg::data_t                            rdata_o,
  // arbiter side
  output logic [tcdm_pkg::NUM_BANKS-1:0]             req_o,      // one-hot bank request
  input  logic [tcdm_pkg::NUM_BANKS-1:0]             gnt_i,
  output tcdm_pkg::req_payload_t                     payload_o,
  input  tcdm_pkg::data_t [tcdm_pkg::NUM_BANKS-1:0]  rdata_i
);

  tcdm_pkg::bank_sel_t bank_sel;
  tcdm_pkg::row_addr_t row;
  tcdm_pkg::bank_sel_t bank_q;   // bank of the last transfer
  logic                vld_q;

  //////////////////////////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////////////////////////

  // word interleaving, bank from the low bits
  assign bank_sel = addr_i[tcdm_pkg::BANK_SEL_W-1:0];
  assign row      = addr_i[tcdm_pkg::ADDR_W-1:tcdm_pkg::BANK_SEL_W];

  always_comb begin
    req_o           = '0;
    req_o[bank_sel] = req_i;
  end

  assign payload_o = {wen_i, row, wdata_i};

  // only the addressed bank's grant counts
  assign gnt_o = req_i & gnt_i[bank_sel];

  //////////////////////////////////////////////////////////////////////
  // response path, fixed one cycle
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q  <= 1'b0;
      bank_q <= '0;
    end else begin
      // reads always answer, writes only when enabled
      vld_q <= gnt_o & (~wen_i | wresp_en_i);
      if (gnt_o) begin
        bank_q <= bank_sel; // hold last bank otherwise
      end
    end
  end

  assign vld_o   = vld_q;
  assign rdata_o = rdata_i[bank_q]; // bank output is one cycle late as well

endmodule

`default_nettype wire

//--- rtl/xbar.sv
`default_nettype none

module xbar (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // steering from the config block
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                    wresp_en_i,
  input  logic                                                ext_prio_en_i,
  input  tcdm_pkg::master_idx_t [tcdm_pkg::NUM_BANKS-1:0]     prio_i,
  // master side
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                    req_i,
  input  tcdm_pkg::word_addr_t [tcdm_pkg::NUM_MASTERS-1:0]    addr_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                    wen_i,
  input  tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]         wdata_i,
  output logic [tcdm_pkg::NUM_MASTERS-1:0]                    gnt_o,
  output logic [tcdm_pkg::NUM_MASTERS-1:0]                    vld_o,
  output tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]         rdata_o,
  // bank side
  output logic [tcdm_pkg::NUM_BANKS-1:0]                      bank_req_o,
  input  logic [tcdm_pkg::NUM_BANKS-1:0]                      bank_gnt_i,
  output tcdm_pkg::req_payload_t [tcdm_pkg::NUM_BANKS-1:0]    bank_payload_o,
  input  tcdm_pkg::data_t [tcdm_pkg::NUM_BANKS-1:0]           bank_rdata_i
);

  // master-major and bank-major views of the same matrices
  logic [tcdm_pkg::NUM_MASTERS-1:0][tcdm_pkg::NUM_BANKS-1:0] ma_req, ma_gnt;
  logic [tcdm_pkg::NUM_BANKS-1:0][tcdm_pkg::NUM_MASTERS-1:0] sl_req, sl_gnt;
  tcdm_pkg::req_payload_t [tcdm_pkg::NUM_MASTERS-1:0]        ma_payload; // shared by all banks

  //////////////////////////////////////////////////////////////////////
  // one decoder / resp mux per master
  //////////////////////////////////////////////////////////////////////

  for (genvar m = 0; m < tcdm_pkg::NUM_MASTERS; m++) begin : gen_masters
    addr_dec_resp_mux i_addr_dec_resp_mux (
      .clk_i      ( clk_i         ),
      .arst_n_i   ( arst_n_i      ),
      .wresp_en_i ( wresp_en_i[m] ),
      .req_i      ( req_i[m]      ),
      .addr_i     ( addr_i[m]     ),
      .wen_i      ( wen_i[m]      ),
      .wdata_i    ( wdata_i[m]    ),
      .gnt_o      ( gnt_o[m]      ),
      .vld_o      ( vld_o[m]      ),
      .rdata_o    ( rdata_o[m]    ),
      .req_o      ( ma_req[m]     ),
      .gnt_i      ( ma_gnt[m]     ),
      .payload_o  ( ma_payload[m] ),
      .rdata_i    ( bank_rdata_i  )  // every master sees every bank
    );

    // transpose master x bank
    for (genvar b = 0; b < tcdm_pkg::NUM_BANKS; b++) begin : gen_reshape
      assign sl_req[b][m] = ma_req[m][b];
      assign ma_gnt[m][b] = sl_gnt[b][m];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // one arbiter per bank
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < tcdm_pkg::NUM_BANKS; b++) begin : gen_banks
    rr_arbiter i_rr_arbiter (
      .clk_i         ( clk_i             ),
      .arst_n_i      ( arst_n_i          ),
      .ext_prio_en_i ( ext_prio_en_i     ),
      .prio_i        ( prio_i[b]         ),
      .req_i         ( sl_req[b]         ),
      .payload_i     ( ma_payload        ),
      .gnt_o         ( sl_gnt[b]         ),
      .req_o         ( bank_req_o[b]     ),
      .gnt_i         ( bank_gnt_i[b]     ),
      .payload_o     ( bank_payload_o[b] )
    );
  end

endmodule

`default_nettype wire

//--- rtl/mem_bank.sv
`default_nettype none

module mem_bank (
  input  logic                   clk_i,
  input  logic                   req_i,     // already qualified with the bank grant
  input  tcdm_pkg::req_payload_t payload_i,
  output tcdm_pkg::data_t        rdata_o    // valid one cycle after a read
);

  tcdm_pkg::data_t     mem_q [tcdm_pkg::BANK_DEPTH];
  logic                wen;
  tcdm_pkg::row_addr_t row;
  tcdm_pkg::data_t     wdata;

  // unpack what the arbiter forwarded
  assign {wen, row, wdata} = payload_i;

  //////////////////////////////////////////////////////////////////////
  // single port, read or write per cycle
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen) begin
        mem_q[row] <= wdata;
      end else begin
        rdata_o <= mem_q[row]; // old contents, registered
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/xbar_cfg_regs.sv
`default_nettype none

module xbar_cfg_regs (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  // register port
  input  logic                                            cfg_we_i,
  input  logic [tcdm_pkg::CFG_ADDR_W-1:0]                 cfg_addr_i,
  input  tcdm_pkg::data_t                                 cfg_wdata_i,
  output tcdm_pkg::data_t                                 cfg_rdata_o,
  // steering outputs
  output logic [tcdm_pkg::NUM_MASTERS-1:0]                wresp_en_o,
  output logic                                            ext_prio_en_o,
  output tcdm_pkg::master_idx_t [tcdm_pkg::NUM_BANKS-1:0] prio_o
);

  logic [tcdm_pkg::NUM_MASTERS-1:0]                wresp_mask_q; // one bit per master
  logic                                            ext_prio_en_q;
  tcdm_pkg::master_idx_t [tcdm_pkg::NUM_BANKS-1:0] prio_q;       // bank 0 in the low bits

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wresp_mask_q  <= '1;   // write responses on by default
      ext_prio_en_q <= 1'b0;
      prio_q        <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        tcdm_pkg::CFG_ADDR_WRESP: begin
          wresp_mask_q <= cfg_wdata_i[tcdm_pkg::NUM_MASTERS-1:0];
        end
        tcdm_pkg::CFG_ADDR_PRIO: begin
          ext_prio_en_q <= cfg_wdata_i[tcdm_pkg::EXT_PRIO_EN_BIT];
          prio_q        <= cfg_wdata_i[tcdm_pkg::EXT_PRIO_EN_BIT-1:0]; // all four fields
        end
        default: ;
      endcase
    end
  end

  // readback, unused bits read as zero
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      tcdm_pkg::CFG_ADDR_WRESP: cfg_rdata_o[tcdm_pkg::NUM_MASTERS-1:0] = wresp_mask_q;
      tcdm_pkg::CFG_ADDR_PRIO: begin
        cfg_rdata_o[tcdm_pkg::EXT_PRIO_EN_BIT]     = ext_prio_en_q;
        cfg_rdata_o[tcdm_pkg::EXT_PRIO_EN_BIT-1:0] = prio_q;
      end
      default: ;
    endcase
  end

  assign wresp_en_o    = wresp_mask_q;
  assign ext_prio_en_o = ext_prio_en_q; // one enable for all banks
  assign prio_o        = prio_q;

endmodule

`default_nettype wire

//--- rtl/tcdm_top.sv
`default_nettype none

module tcdm_top (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  // masters
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                 req_i,
  input  tcdm_pkg::word_addr_t [tcdm_pkg::NUM_MASTERS-1:0] addr_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                 wen_i,
  input  tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]      wdata_i,
  output logic [tcdm_pkg::NUM_MASTERS-1:0]                 gnt_o,
  output logic [tcdm_pkg::NUM_MASTERS-1:0]                 vld_o,
  output tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]      rdata_o,
  // per-bank back-pressure
  input  logic [tcdm_pkg::NUM_BANKS-1:0]                   bank_stall_i,
  // config port
  input  logic                                             cfg_we_i,
  input  logic [tcdm_pkg::CFG_ADDR_W-1:0]                  cfg_addr_i,
  input  tcdm_pkg::data_t                                  cfg_wdata_i,
  output tcdm_pkg::data_t                                  cfg_rdata_o
);

  logic [tcdm_pkg::NUM_MASTERS-1:0]                   wresp_en;
  logic                                               ext_prio_en;
  tcdm_pkg::master_idx_t [tcdm_pkg::NUM_BANKS-1:0]    prio;
  logic [tcdm_pkg::NUM_BANKS-1:0]                     bank_req, bank_gnt;
  tcdm_pkg::req_payload_t [tcdm_pkg::NUM_BANKS-1:0]   bank_payload;
  tcdm_pkg::data_t [tcdm_pkg::NUM_BANKS-1:0]          bank_rdata;

  //////////////////////////////////////////////////////////////////////
  // config and interconnect
  //////////////////////////////////////////////////////////////////////

  xbar_cfg_regs i_xbar_cfg_regs (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .cfg_we_i      ( cfg_we_i    ),
    .cfg_addr_i    ( cfg_addr_i  ),
    .cfg_wdata_i   ( cfg_wdata_i ),
    .cfg_rdata_o   ( cfg_rdata_o ),
    .wresp_en_o    ( wresp_en    ),
    .ext_prio_en_o ( ext_prio_en ),
    .prio_o        ( prio        )
  );

  assign bank_gnt = ~bank_stall_i; // a stalled bank grants nobody

  xbar i_xbar (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .wresp_en_i     ( wresp_en     ),
    .ext_prio_en_i  ( ext_prio_en  ),
    .prio_i         ( prio         ),
    .req_i          ( req_i        ),
    .addr_i         ( addr_i       ),
    .wen_i          ( wen_i        ),
    .wdata_i        ( wdata_i      ),
    .gnt_o          ( gnt_o        ),
    .vld_o          ( vld_o        ),
    .rdata_o        ( rdata_o      ),
    .bank_req_o     ( bank_req     ),
    .bank_gnt_i     ( bank_gnt     ),
    .bank_payload_o ( bank_payload ),
    .bank_rdata_i   ( bank_rdata   )
  );

  //////////////////////////////////////////////////////////////////////
  // banks
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < tcdm_pkg::NUM_BANKS; b++) begin : gen_mem
    mem_bank i_mem_bank (
      .clk_i     ( clk_i                     ),
      .req_i     ( bank_req[b] & bank_gnt[b] ), // access only when granted
      .payload_i ( bank_payload[b]           ),
      .rdata_o   ( bank_rdata[b]             )
    );
  end

endmodule

`default_nettype wire

//--- verif/tcdm_checker.sv
`default_nettype none

module tcdm_checker (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  logic [7:0]                                       test_id_i,
  input  logic                                             done_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                 req_i,
  input  tcdm_pkg::word_addr_t [tcdm_pkg::NUM_MASTERS-1:0] addr_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                 wen_i,
  input  tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]      wdata_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                 gnt_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]                 vld_i,
  input  tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]      rdata_i,
  input  logic [tcdm_pkg::NUM_BANKS-1:0]                   stall_i,
  input  logic                                             cfg_we_i,
  input  logic [tcdm_pkg::CFG_ADDR_W-1:0]                  cfg_addr_i,
  input  tcdm_pkg::data_t                                  cfg_wdata_i,
  input  tcdm_pkg::data_t                                  cfg_rdata_i,
  output logic [31:0]                                      err_cnt_o
);

  tcdm_pkg::data_t shadow    [256];  // reference memory by word address
  logic            shadow_ok [256];  // written at least once
  logic [3:0]      mask_s;           // shadow config
  logic            prio_en_s;
  logic [7:0]      prio_s;
  logic [1:0]      ptr [4];          // own round-robin pointers
  logic [3:0]      exp_vld, exp_rd;  // what the next cycle must show
  tcdm_pkg::data_t exp_data [4];
  logic [7:0]      cur_id;
  int              test_err;
  logic [31:0]     err_cnt;
  logic            reported;

  assign err_cnt_o = err_cnt;

  initial begin
    err_cnt  = '0;
    test_err = 0;
    cur_id   = '0;
    reported = 1'b0;
    for (int a = 0; a < 256; a++) begin
      shadow_ok[a] = 1'b0;
    end
  end

  // first requester at or after start with a found flag in bit 2
  function automatic logic [2:0] pick(input logic [3:0] reqs, input logic [1:0] start);
    logic [1:0] c;
    pick = '0;
    for (int i = 0; i < 4; i++) begin
      c = start + 2'(i);
      if (!pick[2] && reqs[c]) pick = {1'b1, c};
    end
  endfunction

  task automatic mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
    $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, e, a);
    err_cnt++;
    test_err++;
  endtask

  task automatic report_test();
    $display("test %0d: %s, %0d errors", cur_id, (test_err == 0) ? "ok" : "failed", test_err);
    test_err = 0;
  endtask

  always @(posedge clk_i) begin : watch
    logic [3:0]      reqs;
    logic [1:0]      start;
    logic [2:0]      w;
    logic            exp_g;
    tcdm_pkg::data_t exp_cfg;
    if (!arst_n_i) begin
      mask_s    <= 4'hf;
      prio_en_s <= 1'b0;
      prio_s    <= '0;
      exp_vld   <= '0;
      exp_rd    <= '0;
      for (int b = 0; b < 4; b++) ptr[b] <= '0;
    end else begin
      // responses of last cycle's transfers
      for (int m = 0; m < 4; m++) begin
        if (vld_i[m] !== exp_vld[m]) begin
          mismatch($sformatf("vld_o[%0d]", m), 32'(exp_vld[m]), 32'(vld_i[m]));
        end else if (exp_vld[m] && exp_rd[m] && rdata_i[m] !== exp_data[m]) begin
          mismatch($sformatf("rdata_o[%0d]", m), exp_data[m], rdata_i[m]);
        end
      end

      ////////////////////////////////////////////////////////////////////
      // per-test lines
      ////////////////////////////////////////////////////////////////////
      if (test_id_i != cur_id) begin
        if (cur_id != 0) report_test();
        cur_id = test_id_i;
      end
      if (done_i && !reported) begin
        report_test();
        reported = 1'b1;
      end

      // config readback
      exp_cfg = cfg_addr_i[0] ? tcdm_pkg::data_t'({prio_en_s, prio_s})
                              : tcdm_pkg::data_t'(mask_s);
      if (cfg_rdata_i !== exp_cfg) mismatch("cfg_rdata_o", exp_cfg, cfg_rdata_i);

      // grant rules per bank
      for (int b = 0; b < 4; b++) begin
        for (int m = 0; m < 4; m++) reqs[m] = req_i[m] && addr_i[m][1:0] == 2'(b);
        start = prio_en_s ? prio_s[2*b +: 2] : ptr[b];
        w     = pick(reqs, start);
        for (int m = 0; m < 4; m++) begin
          if (reqs[m]) begin
            exp_g = !stall_i[b] && w[2] && w[1:0] == 2'(m);
            if (gnt_i[m] !== exp_g) begin
              mismatch($sformatf("gnt_o[%0d]", m), 32'(exp_g), 32'(gnt_i[m]));
            end
          end
        end
        if (w[2] && !stall_i[b]) ptr[b] <= w[1:0] + 2'd1; // pointer moves on transfer only
      end
      for (int m = 0; m < 4; m++) begin
        if (!req_i[m] && gnt_i[m] !== 1'b0) begin
          mismatch($sformatf("gnt_o[%0d]", m), 0, 32'(gnt_i[m]));
        end
      end

      // transfers seen now get answered next cycle
      for (int m = 0; m < 4; m++) begin
        exp_vld[m] <= 1'b0;
        exp_rd[m]  <= 1'b0;
        if (req_i[m] && gnt_i[m]) begin
          exp_vld[m] <= !wen_i[m] || mask_s[m];
          if (wen_i[m]) begin
            shadow[addr_i[m]]    = wdata_i[m];
            shadow_ok[addr_i[m]] = 1'b1;
          end else begin
            exp_rd[m]   <= shadow_ok[addr_i[m]]; // unwritten words are not compared
            exp_data[m] <= shadow[addr_i[m]];
          end
        end
      end

      if (cfg_we_i) begin
        if (cfg_addr_i[0]) begin
          prio_en_s <= cfg_wdata_i[8];
          prio_s    <= cfg_wdata_i[7:0];
        end else begin
          mask_s <= cfg_wdata_i[3:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_tcdm_top.sv
`default_nettype none

module tb_tcdm_top;

  localparam int NUM_STEPS    = 24;
  localparam int STEP_MAX_CYC = 8;                              // wait limit per step
  localparam int MAX_CYCLES   = NUM_STEPS * STEP_MAX_CYC + 40;  // whole-run limit

  logic                                             clk, arst_n;
  logic [tcdm_pkg::NUM_MASTERS-1:0]                 req, wen, gnt, vld;
  tcdm_pkg::word_addr_t [tcdm_pkg::NUM_MASTERS-1:0] addr;
  tcdm_pkg::data_t [tcdm_pkg::NUM_MASTERS-1:0]      wdata, rdata;
  logic [tcdm_pkg::NUM_BANKS-1:0]                   stall;
  logic                                             cfg_we;
  logic [tcdm_pkg::CFG_ADDR_W-1:0]                  cfg_addr;
  tcdm_pkg::data_t                                  cfg_wdata, cfg_rdata;
  logic [7:0]                                       test_id;
  logic                                             done;
  logic [31:0]                                      chk_errs;
  int                                               step_errs;
  int                                               cyc_cnt;
  logic [31:0]                                      lcg_state;

  // stimulus table, one row per step
  logic [3:0]                  tab_req   [NUM_STEPS];
  logic [3:0]                  tab_wen   [NUM_STEPS];
  tcdm_pkg::word_addr_t [3:0]  tab_addr  [NUM_STEPS];
  tcdm_pkg::data_t [3:0]       tab_data  [NUM_STEPS];
  logic [3:0]                  tab_stall [NUM_STEPS];
  logic                        tab_cfg_we   [NUM_STEPS];
  logic [0:0]                  tab_cfg_addr [NUM_STEPS];
  tcdm_pkg::data_t             tab_cfg_data [NUM_STEPS];
  logic [7:0]                  tab_id       [NUM_STEPS];

  tcdm_top dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .req_i (req), .addr_i (addr), .wen_i (wen), .wdata_i (wdata),
    .gnt_o (gnt), .vld_o (vld), .rdata_o (rdata),
    .bank_stall_i (stall),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata)
  );

  tcdm_checker i_checker (
    .clk_i (clk), .arst_n_i (arst_n), .test_id_i (test_id), .done_i (done),
    .req_i (req), .addr_i (addr), .wen_i (wen), .wdata_i (wdata),
    .gnt_i (gnt), .vld_i (vld), .rdata_i (rdata), .stall_i (stall),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_i (cfg_rdata), .err_cnt_o (chk_errs)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // period 4
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // table building
  //////////////////////////////////////////////////////////////////////

  task automatic clear_step(input int s, input int id);
    tab_req[s]      = '0;
    tab_wen[s]      = '0;
    tab_addr[s]     = '0;
    tab_data[s]     = '0;
    tab_stall[s]    = '0;
    tab_cfg_we[s]   = 1'b0;
    tab_cfg_addr[s] = (s > 0) ? tab_cfg_addr[s-1] : 1'b0; // readback address sticks
    tab_cfg_data[s] = '0;
    tab_id[s]       = 8'(id);
  endtask

  task automatic put_req(input int s, input int m, input int a, input logic w);
    lcg_state              = lcg_next(lcg_state);
    tab_req[s][2'(m)]      = 1'b1;
    tab_wen[s][2'(m)]      = w;
    tab_addr[s][2'(m)]     = tcdm_pkg::word_addr_t'(a); // {row, bank}
    tab_data[s][2'(m)]     = lcg_state;
  endtask

  task automatic put_cfg(input int s, input logic a, input logic [31:0] d);
    tab_cfg_we[s]   = 1'b1;
    tab_cfg_addr[s] = a;
    tab_cfg_data[s] = d;
  endtask

  task automatic build_table();
    for (int i = 0; i < 4; i++) begin   // single master, all banks, write then read
      clear_step(i, 1);
      put_req(i, 0, 4 + i, 1'b1);
      clear_step(i + 4, 1);
      put_req(i + 4, 0, 4 + i, 1'b0);
    end
    clear_step(8, 2);                   // distinct banks, same cycle
    clear_step(9, 2);
    for (int m = 0; m < 4; m++) begin
      put_req(8, m, 32 + (m + 1) % 4, 1'b1);
      put_req(9, m, 32 + (m + 1) % 4, 1'b0);
    end
    clear_step(10, 3);                  // everybody on bank 3
    clear_step(11, 3);
    clear_step(12, 3);
    for (int m = 0; m < 4; m++) begin
      put_req(10, m, (12 + m) * 4 + 3, 1'b1);
      put_req(11, m, (12 + m) * 4 + 3, 1'b0);
      put_req(12, m, (12 + m) * 4 + 3, 1'b0);
    end
    clear_step(13, 4);
    put_cfg(13, 1'b0, 32'hd);           // master 1 write responses off
    clear_step(14, 4);
    put_req(14, 0, 64, 1'b1);
    put_req(14, 1, 65, 1'b1);
    clear_step(15, 4);
    put_req(15, 0, 64, 1'b0);
    put_req(15, 1, 65, 1'b0);
    clear_step(16, 5);
    put_cfg(16, 1'b1, 32'h130);         // ext prio on, bank 2 -> master 3
    clear_step(17, 5);
    clear_step(18, 5);
    for (int m = 0; m < 4; m++) begin
      put_req(17, m, (20 + m) * 4 + 2, 1'b1);
      put_req(18, m, (20 + m) * 4 + 2, 1'b0);
    end
    clear_step(19, 6);                  // bank 0 stalled
    put_cfg(19, 1'b0, 32'hf);
    put_req(19, 0, 4, 1'b0);
    put_req(19, 1, 5, 1'b0);
    tab_stall[19] = 4'b0001;
    clear_step(20, 6);
    put_req(20, 0, 4, 1'b0);            // same read, bank released
    clear_step(21, 6);
    put_req(21, 0, 4, 1'b1);
    put_req(21, 2, 6, 1'b1);
    tab_stall[21] = 4'b0001;
    clear_step(22, 6);
    tab_req[22]  = tab_req[21];         // held request, same data
    tab_wen[22]  = tab_wen[21];
    tab_addr[22] = tab_addr[21];
    tab_data[22] = tab_data[21];
    clear_step(23, 6);
    put_req(23, 0, 4, 1'b0);
    put_req(23, 2, 6, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // step execution
  //////////////////////////////////////////////////////////////////////

  // entered right after a falling edge
  task automatic run_step(input int s);
    logic [3:0] served;
    int         cyc;
    served    = '0;
    cyc       = 0;
    req       = tab_req[s];
    wen       = tab_wen[s];
    addr      = tab_addr[s];
    wdata     = tab_data[s];
    stall     = tab_stall[s];
    cfg_we    = tab_cfg_we[s];
    cfg_addr  = tab_cfg_addr[s];
    cfg_wdata = tab_cfg_data[s];
    test_id   = tab_id[s];
    do begin
      @(posedge clk);
      served = served | (req & gnt);
      cyc++;
      @(negedge clk);
      cfg_we = 1'b0;                   // one config write per step
      req    = tab_req[s] & ~served;   // granted masters drop out
    end while (served != tab_req[s] && cyc < STEP_MAX_CYC);
    for (int m = 0; m < 4; m++) begin
      if (tab_req[s][2'(m)] && !served[2'(m)] && !tab_stall[s][tab_addr[s][2'(m)][1:0]]) begin
        $display("step %0d: master %0d was never granted", s, m);
        step_errs++;
      end
    end
    if (tab_stall[s] == '0 && cyc > 4) begin
      $display("step %0d: serving all masters took %0d cycles", s, cyc);
      step_errs++;
    end
  endtask

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYCLES) begin
      $display("timeout: run went past %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    arst_n    = 1'b0;
    req       = '0;
    wen       = '0;
    addr      = '0;
    wdata     = '0;
    stall     = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    test_id   = '0;
    done      = 1'b0;
    step_errs = 0;
    cyc_cnt   = 0;
    lcg_state = 32'd24008;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int s = 0; s < NUM_STEPS; s++) begin
      run_step(s);
    end
    req = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    done = 1'b1;                        // flush the last test line
    @(posedge clk);
    @(negedge clk);
    $display("summary: %0d steps, %0d checker errors, %0d step errors",
             NUM_STEPS, chk_errs, step_errs);
    if (chk_errs == 0 && step_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
rtl/tcdm_pkg.sv
rtl/rr_arbiter.sv
rtl/addr_dec_resp_mux.sv
rtl/xbar.sv
rtl/mem_bank.sv
rtl/xbar_cfg_regs.sv
rtl/tcdm_top.sv
verif/tcdm_checker.sv
verif/tb_tcdm_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f compile.f --top-module tb_tcdm_top -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "ALL TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
